//--- rtl/alu_mul_pkg.sv
package alu_mul_pkg;

  localparam int XLEN   = 64;
  localparam int EXT_W  = XLEN + 2;   // Room for sign of unsigned operands.
  localparam int PP_W   = 2 * XLEN;
  localparam int PP_NUM = EXT_W / 2;  // One Booth digit per bit pair.

  typedef logic [XLEN-1:0]  xlen_t;
  typedef logic [EXT_W-1:0] ext_t;
  typedef logic [PP_W-1:0]  pp_t;

  // Aligned partial products.
  typedef pp_t [PP_NUM-1:0] pp_vec_t;

  typedef enum logic [2:0] {
    MUL    = 3'd0,
    MULH   = 3'd1,
    MULHSU = 3'd2,
    MULHU  = 3'd3,
    MULW   = 3'd4
  } mul_op_e;

  typedef struct packed {
    mul_op_e op;
    xlen_t   rs1;
    xlen_t   rs2;
  } mul_req_t;

  typedef struct packed {
    logic take_high;  // Upper half of the product.
    logic word;       // Sign-extend low 32 bits.
  } mul_sel_t;

  // Stage 1 register.
  typedef struct packed {
    pp_t      sum;
    pp_t      carry;
    mul_sel_t sel;
  } mul_cs_t;

endpackage

//--- rtl/alu_mul_op_decode.sv
`timescale 1ns/1ps

module alu_mul_op_decode (
  input  alu_mul_pkg::mul_op_e  op_i,
  output logic                  rs1_signed_o,
  output logic                  rs2_signed_o,
  output alu_mul_pkg::mul_sel_t sel_o
);

  always_comb begin
    rs1_signed_o  = 1'b0;
    rs2_signed_o  = 1'b0;
    sel_o         = '0;
    case (op_i)
      alu_mul_pkg::MUL: begin
        sel_o.take_high = 1'b0;  // Low half, signedness irrelevant.
      end
      alu_mul_pkg::MULH: begin
        rs1_signed_o    = 1'b1;
        rs2_signed_o    = 1'b1;
        sel_o.take_high = 1'b1;
      end
      alu_mul_pkg::MULHSU: begin
        rs1_signed_o    = 1'b1;
        sel_o.take_high = 1'b1;
      end
      alu_mul_pkg::MULHU: begin
        sel_o.take_high = 1'b1;
      end
      alu_mul_pkg::MULW: begin
        sel_o.word = 1'b1;
      end
      default: begin
        sel_o = '0;
      end
    endcase
  end

endmodule

//--- rtl/alu_mul_booth_r4.sv
`timescale 1ns/1ps

module alu_mul_booth_r4 (
  input  logic                      rs1_signed_i,
  input  logic                      rs2_signed_i,
  input  alu_mul_pkg::xlen_t        rs1_i,
  input  alu_mul_pkg::xlen_t        rs2_i,
  output wire alu_mul_pkg::pp_vec_t pp_o
);

  alu_mul_pkg::ext_t x;
  alu_mul_pkg::ext_t y;
  alu_mul_pkg::ext_t x_dbl;
  alu_mul_pkg::ext_t x_neg;
  alu_mul_pkg::ext_t x_neg_dbl;
  logic [alu_mul_pkg::EXT_W:0] scan;
  logic x_nz;

  assign x = rs1_signed_i ? {{2{rs1_i[alu_mul_pkg::XLEN-1]}}, rs1_i} : {2'b00, rs1_i};
  assign y = rs2_signed_i ? {{2{rs2_i[alu_mul_pkg::XLEN-1]}}, rs2_i} : {2'b00, rs2_i};

  assign x_dbl     = x << 1;
  assign x_neg     = ~x + 1'b1;
  assign x_neg_dbl = x_neg << 1;
  assign x_nz      = |x;
  assign scan      = {y, 1'b0};  // Implicit y[-1] of zero.

  genvar i;
  generate
    for (i = 0; i < alu_mul_pkg::PP_NUM; i++) begin : gen_pp
      wire [2:0] grp     = scan[2*i+2 -: 3];
      wire       sel_x   = (grp == 3'b001) | (grp == 3'b010);
      wire       sel_2x  = (grp == 3'b011);
      wire       sel_n   = (grp == 3'b101) | (grp == 3'b110);
      wire       sel_n2x = (grp == 3'b100);
      wire alu_mul_pkg::ext_t raw = ({alu_mul_pkg::EXT_W{sel_x}}   & x)
                                  | ({alu_mul_pkg::EXT_W{sel_2x}}  & x_dbl)
                                  | ({alu_mul_pkg::EXT_W{sel_n}}   & x_neg)
                                  | ({alu_mul_pkg::EXT_W{sel_n2x}} & x_neg_dbl);
      // True sign, raw alone overflows for 2x and -2x.
      wire pp_sign = ((sel_x | sel_2x) & x[alu_mul_pkg::EXT_W-1])
                   | ((sel_n | sel_n2x) & ~x[alu_mul_pkg::EXT_W-1] & x_nz);
      wire alu_mul_pkg::pp_t pp_ext =
        {{(alu_mul_pkg::PP_W - alu_mul_pkg::EXT_W){pp_sign}}, raw};

      assign pp_o[i] = pp_ext << (2 * i);  // Top bits of the last one drop off.
    end
  endgenerate

endmodule

//--- rtl/alu_mul_csa_tree.sv
`timescale 1ns/1ps

module alu_mul_csa_tree (
  input  alu_mul_pkg::pp_vec_t pp_i,
  output alu_mul_pkg::pp_t     sum_o,
  output alu_mul_pkg::pp_t     carry_o
);

  // Vectors left after k layers.
  function automatic int layer_cnt(input int k);
    int n;
    n = alu_mul_pkg::PP_NUM;
    for (int j = 0; j < k; j++) begin
      n = 2 * (n / 3) + n % 3;
    end
    return n;
  endfunction

  // Layers needed to reach a pair.
  function automatic int layer_num();
    int k;
    k = 0;
    while (layer_cnt(k) > 2) begin
      k++;
    end
    return k;
  endfunction

  wire alu_mul_pkg::pp_t lvl [0:layer_num()][0:alu_mul_pkg::PP_NUM-1];

  genvar i;
  genvar l;
  genvar g;
  genvar r;
  generate
    for (i = 0; i < alu_mul_pkg::PP_NUM; i++) begin : gen_in
      assign lvl[0][i] = pp_i[i];
    end

    for (l = 0; l < layer_num(); l++) begin : gen_layer
      // Full 3:2 groups.
      for (g = 0; g < layer_cnt(l) / 3; g++) begin : gen_csa
        wire alu_mul_pkg::pp_t a = lvl[l][3*g];
        wire alu_mul_pkg::pp_t b = lvl[l][3*g+1];
        wire alu_mul_pkg::pp_t c = lvl[l][3*g+2];

        assign lvl[l+1][2*g]   = a ^ b ^ c;
        assign lvl[l+1][2*g+1] = ((a & b) | (a & c) | (b & c)) << 1;
      end

      // Leftovers skip this layer.
      for (r = 0; r < layer_cnt(l) % 3; r++) begin : gen_pass
        assign lvl[l+1][2*(layer_cnt(l)/3)+r] = lvl[l][3*(layer_cnt(l)/3)+r];
      end
    end
  endgenerate

  assign sum_o   = lvl[layer_num()][0];
  assign carry_o = lvl[layer_num()][1];

endmodule

//--- rtl/alu_mul_result_sel.sv
`timescale 1ns/1ps

module alu_mul_result_sel (
  input  alu_mul_pkg::pp_t      sum_i,
  input  alu_mul_pkg::pp_t      carry_i,
  input  alu_mul_pkg::mul_sel_t sel_i,
  output alu_mul_pkg::xlen_t    result_o
);

  alu_mul_pkg::pp_t prod;

  assign prod = sum_i + carry_i;  // Modulo 2^128.

  always_comb begin
    if (sel_i.take_high) begin
      result_o = prod[alu_mul_pkg::PP_W-1:alu_mul_pkg::XLEN];
    end else if (sel_i.word) begin
      result_o = {{(alu_mul_pkg::XLEN-32){prod[31]}}, prod[31:0]};
    end else begin
      result_o = prod[alu_mul_pkg::XLEN-1:0];
    end
  end

endmodule

//--- rtl/alu_mul.sv
`timescale 1ns/1ps

module alu_mul (
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  logic                  valid_i,
  input  alu_mul_pkg::mul_req_t req_i,
  output logic                  valid_o,
  output alu_mul_pkg::xlen_t    result_o
);

  logic                  rs1_signed;
  logic                  rs2_signed;
  alu_mul_pkg::mul_sel_t sel;
  alu_mul_pkg::pp_vec_t  pp;
  alu_mul_pkg::pp_t      sum;
  alu_mul_pkg::pp_t      carry;
  alu_mul_pkg::mul_cs_t  cs_q;
  logic                  valid_s1;
  alu_mul_pkg::xlen_t    result_d;

  alu_mul_op_decode u_decode (
    .op_i         (req_i.op),
    .rs1_signed_o (rs1_signed),
    .rs2_signed_o (rs2_signed),
    .sel_o        (sel)
  );

  alu_mul_booth_r4 u_booth (
    .rs1_signed_i (rs1_signed),
    .rs2_signed_i (rs2_signed),
    .rs1_i        (req_i.rs1),
    .rs2_i        (req_i.rs2),
    .pp_o         (pp)
  );

  alu_mul_csa_tree u_csa (
    .pp_i    (pp),
    .sum_o   (sum),
    .carry_o (carry)
  );

  // Stage 1. Carry-save pair and selection flags.
  always_ff @(posedge clk_i) begin
    cs_q.sum   <= sum;
    cs_q.carry <= carry;
    cs_q.sel   <= sel;
  end

  alu_mul_result_sel u_sel (
    .sum_i    (cs_q.sum),
    .carry_i  (cs_q.carry),
    .sel_i    (cs_q.sel),
    .result_o (result_d)
  );

  // Stage 2.
  always_ff @(posedge clk_i) begin
    result_o <= result_d;
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      valid_s1 <= 1'b0;
      valid_o  <= 1'b0;
    end else begin
      valid_s1 <= valid_i;
      valid_o  <= valid_s1;  // Two cycles after the request.
    end
  end

endmodule

//--- verif/tb_alu_mul.sv
`timescale 1ns/1ps

module tb_alu_mul;

  localparam int          RESET_CYCLES   = 4;
  localparam int          LATENCY        = 2;
  localparam int          RESULT_TIMEOUT = 10;
  localparam int          DRAIN_TIMEOUT  = 20;
  localparam int          N_B2B          = 400;
  localparam int          N_GAP          = 300;
  localparam logic [31:0] LFSR_SEED      = 32'd28;

  logic                  clk_i;
  logic                  reset_i;
  logic                  valid_i;
  alu_mul_pkg::mul_req_t req_i;
  logic                  valid_o;
  alu_mul_pkg::xlen_t    result_o;

  logic [31:0] lfsr_state;
  int          cycle_cnt;
  int          n_issued;
  int          n_checked;
  logic        checking;

  // Outstanding requests, oldest first.
  alu_mul_pkg::mul_req_t req_q [$];
  alu_mul_pkg::xlen_t    exp_q [$];
  int                    tag_q [$];  // Cycle in which the request is driven.

  alu_mul UUT (
    .clk_i    (clk_i),
    .reset_i  (reset_i),
    .valid_i  (valid_i),
    .req_i    (req_i),
    .valid_o  (valid_o),
    .result_o (result_o)
  );

  always #2 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
  end

  // x^32 + x^22 + x^2 + x + 1.
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  // One LFSR step per bit.
  task automatic take_bits(input int n, output logic [63:0] v);
    v = '0;
    for (int k = 0; k < n; k++) begin
      lfsr_state = lfsr_next(lfsr_state);
      v = {v[62:0], lfsr_state[0]};
    end
  endtask

  function automatic alu_mul_pkg::xlen_t corner_val(input int idx);
    case (idx)
      0:       return 64'd0;
      1:       return 64'd1;
      2:       return {64{1'b1}};
      3:       return 64'h8000_0000_0000_0000;  // Most negative.
      default: return 64'h7fff_ffff_ffff_ffff;  // Most positive.
    endcase
  endfunction

  task automatic rand_operand(output alu_mul_pkg::xlen_t v);
    logic [63:0] cls;
    logic [63:0] idx;
    take_bits(2, cls);
    if (cls == 0) begin
      take_bits(3, idx);
      v = corner_val(int'(idx % 5));
    end else begin
      take_bits(64, v);
    end
  endtask

  task automatic rand_req(output alu_mul_pkg::mul_req_t r);
    logic [63:0] bits;
    take_bits(3, bits);
    r.op = alu_mul_pkg::mul_op_e'(3'(bits % 5));
    rand_operand(r.rs1);
    rand_operand(r.rs2);
  endtask

  // Reference model with full 128-bit products.
  function automatic alu_mul_pkg::xlen_t expected_result(input alu_mul_pkg::mul_req_t r);
    logic [127:0]        a_u;
    logic [127:0]        b_u;
    logic signed [127:0] a_s;
    logic signed [127:0] b_s;
    logic [127:0]        p;
    a_u = {64'd0, r.rs1};
    b_u = {64'd0, r.rs2};
    a_s = {{64{r.rs1[63]}}, r.rs1};
    b_s = {{64{r.rs2[63]}}, r.rs2};
    case (r.op)
      alu_mul_pkg::MULH:   p = a_s * b_s;
      alu_mul_pkg::MULHSU: p = a_s * $signed(b_u);  // rs2 stays zero extended.
      default:             p = a_u * b_u;
    endcase
    case (r.op)
      alu_mul_pkg::MUL:    return p[63:0];
      alu_mul_pkg::MULW:   return {{32{p[31]}}, p[31:0]};
      default:             return p[127:64];
    endcase
  endfunction

  task automatic fail_run();
    $display("Finished with errors");
    $fatal(1, "Simulation stopped at the first failure.");
  endtask

  task automatic check_result(input alu_mul_pkg::xlen_t expected,
                              input alu_mul_pkg::xlen_t actual,
                              input string              what);
    if (actual !== expected) begin
      $display("error %0t: %s result expected %h, got %h", $time, what, expected, actual);
      fail_run();
    end
  endtask

  task automatic check_valid(input logic expected, input logic actual, input string what);
    if (actual !== expected) begin
      $display("error %0t: %s expected %b, got %b", $time, what, expected, actual);
      fail_run();
    end
  endtask

  // Outputs are sampled on the falling edge, away from the register updates.
  always @(negedge clk_i) begin
    logic                  due;
    alu_mul_pkg::mul_req_t r;
    alu_mul_pkg::xlen_t    exp_val;
    if (checking) begin
      due = (tag_q.size() > 0) && (tag_q[0] + LATENCY == cycle_cnt);
      check_valid(due, valid_o, $sformatf("valid_o in cycle %0d", cycle_cnt));
      if (valid_o === 1'b1) begin
        r       = req_q.pop_front();
        exp_val = exp_q.pop_front();
        void'(tag_q.pop_front());
        check_result(exp_val, result_o,
                     $sformatf("%s rs1=%h rs2=%h", r.op.name(), r.rs1, r.rs2));
        n_checked++;
      end
    end
  end

  task automatic issue_req(input alu_mul_pkg::mul_req_t r);
    @(negedge clk_i);
    valid_i = 1'b1;
    req_i   = r;
    req_q.push_back(r);
    exp_q.push_back(expected_result(r));
    tag_q.push_back(cycle_cnt);
    n_issued++;
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(negedge clk_i);
      valid_i = 1'b0;
    end
  endtask

  task automatic wait_result(input int limit);
    int n;
    n = 0;
    while (valid_o !== 1'b1 && n < limit) begin
      @(negedge clk_i);
      n++;
    end
    if (valid_o !== 1'b1) begin
      $display("No result arrived within %0d cycles of a single request.", limit);
      fail_run();
    end
  endtask

  task automatic drain_results(input int limit);
    int n;
    n = 0;
    while (exp_q.size() > 0 && n < limit) begin
      @(negedge clk_i);
      valid_i = 1'b0;
      n++;
    end
    if (exp_q.size() > 0) begin
      $display("No result arrived for %0d outstanding requests within %0d cycles.",
               exp_q.size(), limit);
      fail_run();
    end
  endtask

  // One request per operation, each waited for on its own.
  task automatic single_requests();
    alu_mul_pkg::mul_req_t r;
    for (int o = 0; o < 5; o++) begin
      r.op  = alu_mul_pkg::mul_op_e'(3'(o));
      r.rs1 = 64'hffff_ffff_fffc_7fc7;
      r.rs2 = 64'h0000_0000_8000_02a6;
      issue_req(r);
      idle_cycles(1);
      wait_result(RESULT_TIMEOUT);
    end
  endtask

  // All corner pairs for every operation, back to back.
  task automatic corner_sweep();
    alu_mul_pkg::mul_req_t r;
    for (int o = 0; o < 5; o++) begin
      for (int i = 0; i < 5; i++) begin
        for (int j = 0; j < 5; j++) begin
          r.op  = alu_mul_pkg::mul_op_e'(3'(o));
          r.rs1 = corner_val(i);
          r.rs2 = corner_val(j);
          issue_req(r);
        end
      end
    end
  endtask

  task automatic random_back_to_back(input int n);
    alu_mul_pkg::mul_req_t r;
    for (int k = 0; k < n; k++) begin
      rand_req(r);
      issue_req(r);
    end
  endtask

  task automatic random_with_gaps(input int n);
    alu_mul_pkg::mul_req_t r;
    logic [63:0]           gap;
    logic [63:0]           len;
    for (int k = 0; k < n; k++) begin
      take_bits(2, gap);
      if (gap == 0) begin
        take_bits(2, len);
        idle_cycles(int'(len) + 1);
      end
      rand_req(r);
      issue_req(r);
    end
  endtask

  initial begin
    clk_i      = 1'b0;
    reset_i    = 1'b1;
    valid_i    = 1'b0;
    req_i      = '0;
    lfsr_state = LFSR_SEED;
    cycle_cnt  = 0;
    n_issued   = 0;
    n_checked  = 0;
    checking   = 1'b0;

    repeat (RESET_CYCLES) @(posedge clk_i);
    @(negedge clk_i);
    reset_i  = 1'b0;
    checking = 1'b1;

    // Quiet after reset.
    idle_cycles(8);

    single_requests();
    idle_cycles(4);

    corner_sweep();
    drain_results(DRAIN_TIMEOUT);

    random_back_to_back(N_B2B);
    drain_results(DRAIN_TIMEOUT);

    random_with_gaps(N_GAP);
    drain_results(DRAIN_TIMEOUT);

    // No late strobes.
    idle_cycles(6);

    $display("%0d requests issued, %0d results checked", n_issued, n_checked);
    $display("Finished with no errors");
    $finish;
  end

endmodule

//--- src.f
rtl/alu_mul_pkg.sv
rtl/alu_mul_op_decode.sv
rtl/alu_mul_booth_r4.sv
rtl/alu_mul_csa_tree.sv
rtl/alu_mul_result_sel.sv
rtl/alu_mul.sv
verif/tb_alu_mul.sv
